//--- Makefile
TOP := tb_taylor_multicore

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f hw/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module taylor_multicore

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_taylor_multicore.sv
`timescale 1ns/100ps

module tb_taylor_multicore;

	localparam int NUM_CORES = 2;
	localparam int STAGGER_CYCLES = 6;
	localparam int OUT_CREDITS = 2;
	localparam int N = 10;
	localparam int RELEASE_CYCLES = (NUM_CORES + 1) * STAGGER_CYCLES + 8;
	localparam int TIMEOUT_CYCLES = N * (taylor_pkg::ORDER + 20) + RELEASE_CYCLES;

	// Sample in Q2.16, its tag, and the hold-off before its credit returns.
	localparam int TBL_VALUE [N] = '{0, 65536, -65536, 32768, -98304,
		262143, -262144, 102944, -205887, 12345};
	localparam logic [7:0] TBL_TAG [N] = '{8'h05, 8'hf0, 8'h3c, 8'h81, 8'h00,
		8'hff, 8'h7e, 8'h42, 8'hc3, 8'h19};
	localparam int TBL_HOLD [N] = '{0, 3, 1, 0, 5, 2, 0, 4, 1, 6};

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	taylor_pkg::sample_s in_sample;
	logic                out_credit;
	logic                in_credit;
	logic                out_valid;
	taylor_pkg::result_s out_result;

	logic [31:0] lfsr;
	longint      expected [N];
	bit          seen [N];
	int          credit_total;
	int          up_credits;
	int          out_avail;
	int          sent;
	int          received;
	bit          sending;
	int          returns [$]; // Countdowns to out_credit pulses.

	taylor_multicore #(
		.NUM_CORES      (NUM_CORES),
		.STAGGER_CYCLES (STAGGER_CYCLES),
		.OUT_CREDITS    (OUT_CREDITS)
	) u_taylor_multicore (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Sine series by Horner's rule with a floor after each product.
	function automatic longint horner_ref(input longint x);
		longint acc;
		acc = longint'(taylor_pkg::COEF[taylor_pkg::ORDER]);
		for (int p = taylor_pkg::ORDER - 1; p >= 0; p--) begin
			acc = ((acc * x) >>> taylor_pkg::FRAC_BITS)
				+ longint'(taylor_pkg::COEF[p]);
		end
		return acc;
	endfunction

	function automatic int tag_index(input logic [7:0] tag);
		int idx;
		idx = -1;
		for (int i = 0; i < N; i++) begin
			if (TBL_TAG[i] == tag) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input longint got, input longint exp);
		if (got != exp) begin
			fail_run($sformatf("FAILED at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic cycle_step();
		int  idx;
		int  gap;
		bit  pulse;
		@(posedge clk);
		#1;
		if (in_credit) begin
			credit_total++;
			up_credits++;
		end
		if (out_valid) begin
			if (!sending) begin
				fail_run("A result came out before any sample was sent.");
			end
			if (out_avail == 0) begin
				fail_run("A result was sent while downstream held no credit for it.");
			end
			out_avail--;
			idx = tag_index(out_result.tag);
			if (idx < 0) begin
				fail_run($sformatf("A result carried the unknown tag %0h.", out_result.tag));
			end
			if (seen[idx]) begin
				fail_run($sformatf("The tag %0h came out twice.", out_result.tag));
			end
			check_value("out_result.value", longint'(out_result.value), expected[idx]);
			seen[idx] = 1'b1;
			received++;
			draw_bits(2, gap);
			returns.push_back(TBL_HOLD[idx] + gap);
		end
		pulse = 1'b0;
		for (int i = 0; i < returns.size(); i++) begin
			if (!pulse && returns[i] == 0) begin
				returns.delete(i);
				pulse = 1'b1; // One credit per cycle.
			end
		end
		for (int i = 0; i < returns.size(); i++) begin
			if (returns[i] > 0) begin
				returns[i]--;
			end
		end
		out_credit = pulse;
		if (pulse) begin
			out_avail++;
		end
		if (sending && up_credits > 0 && sent < N) begin
			in_valid = 1'b1;
			in_sample.value = taylor_pkg::sample_t'(TBL_VALUE[sent]);
			in_sample.tag = TBL_TAG[sent];
			up_credits--;
			sent++;
		end else begin
			in_valid = 1'b0;
		end
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		fail_run("Timed out before all results came back.");
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;
		out_credit = 1'b0;
		lfsr = 32'hb727;
		credit_total = 0;
		up_credits = 0;
		out_avail = OUT_CREDITS;
		sent = 0;
		received = 0;
		sending = 1'b0;
		for (int i = 0; i < N; i++) begin
			expected[i] = horner_ref(longint'(TBL_VALUE[i]));
			seen[i] = 1'b0;
		end
		repeat (2) @(posedge clk);
		#1;
		check_value("in_credit", longint'(in_credit), 0);
		check_value("out_valid", longint'(out_valid), 0);
		rst_n = 1'b1;
		repeat (RELEASE_CYCLES) cycle_step(); // Staggered release with nothing sent.
		check_value("in_credit pulses after release", credit_total, NUM_CORES);
		sending = 1'b1;
		while (received < N) begin
			cycle_step();
		end
		repeat (4) cycle_step();
		check_value("in_credit pulses", credit_total, NUM_CORES + received);
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- hw/reset_stagger.sv
`timescale 1ns/100ps

module reset_stagger #(
	parameter int NUM_CORES = 2,
	parameter int STAGGER_CYCLES = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [NUM_CORES-1:0] run
);

	localparam int CNT_W = $clog2(STAGGER_CYCLES + 1);
	localparam int IDX_W = $clog2(NUM_CORES + 1);

	logic [CNT_W-1:0] cnt;
	logic [IDX_W-1:0] idx;
	logic             busy;

	assign busy = (idx != IDX_W'(NUM_CORES)); // Cores left to release.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			idx <= '0;
			run <= '0;
		end else if (busy) begin
			if (cnt == CNT_W'(STAGGER_CYCLES - 1)) begin
				cnt <= '0;
				idx <= idx + IDX_W'(1);
				for (int k = 0; k < NUM_CORES; k++) begin
					if (idx == IDX_W'(k)) begin
						run[k] <= 1'b1; // Stays set until reset.
					end
				end
			end else begin
				cnt <= cnt + CNT_W'(1);
			end
		end
	end

	// Enables form a growing thermometer from bit 0 and never drop.
	a_run_order: assert property (@(posedge clk) disable iff (!rst_n)
		((run & (run + NUM_CORES'(1))) == '0) && (($past(run) & ~run) == '0));

endmodule

//--- hw/result_arbiter.sv
`timescale 1ns/100ps

module result_arbiter #(
	parameter int NUM_CORES = 2,
	parameter int OUT_CREDITS = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_CORES-1:0] done,
	input  taylor_pkg::result_s  core_result [NUM_CORES],
	input  logic                 out_credit,
	output logic [NUM_CORES-1:0] take,
	output taylor_pkg::result_s  out_result,
	output logic                 out_valid
);

	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	logic [CRD_W-1:0]     credits;
	logic [NUM_CORES-1:0] grant;
	taylor_pkg::result_s  sel;
	logic                 fire;

	always_comb begin
		grant = '0;
		sel = core_result[0];
		for (int k = NUM_CORES - 1; k >= 0; k--) begin
			if (done[k]) begin
				grant = NUM_CORES'(1) << k; // Lowest index has priority.
				sel = core_result[k];
			end
		end
	end

	// Wait for the taken core to leave HOLD before choosing again.
	assign fire = (credits != '0) && (take == '0) && (done != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits   <= CRD_W'(OUT_CREDITS);
			take      <= '0;
			out_valid <= 1'b0;
		end else begin
			credits   <= credits - CRD_W'(fire) + CRD_W'(out_credit);
			take      <= fire ? grant : '0;
			out_valid <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			out_result <= sel;
		end
	end

	// Downstream never returns more credits than it was sent results.
	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CRD_W'(OUT_CREDITS));

endmodule

//--- hw/sample_dispatcher.sv
`timescale 1ns/100ps

module sample_dispatcher #(
	parameter int NUM_CORES = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_CORES-1:0] run,
	input  logic                 in_valid,
	input  taylor_pkg::sample_s  in_sample,
	input  logic [NUM_CORES-1:0] take,
	output logic                 in_credit,
	output logic [NUM_CORES-1:0] load,
	output taylor_pkg::sample_s  core_sample
);

	localparam int CRD_W = $clog2(2 * NUM_CORES + 1);

	logic [NUM_CORES-1:0] run_q;
	logic [NUM_CORES-1:0] rise;
	logic [NUM_CORES-1:0] idle;
	logic [NUM_CORES-1:0] pick;
	logic [NUM_CORES-1:0] load_next;
	logic [CRD_W-1:0]     pending;
	logic [CRD_W-1:0]     avail;
	logic                 issue;

	assign rise = run & ~run_q;

	// Each release and each freed core owes upstream one credit.
	assign avail = pending + CRD_W'($countones(rise)) + CRD_W'($countones(take));
	assign issue = (avail != '0);

	always_comb begin
		pick = '0;
		for (int k = NUM_CORES - 1; k >= 0; k--) begin
			if (idle[k]) begin
				pick = NUM_CORES'(1) << k; // Lowest idle core wins.
			end
		end
	end

	assign load_next = in_valid ? pick : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q     <= '0;
			idle      <= '0;
			pending   <= '0;
			in_credit <= 1'b0;
			load      <= '0;
		end else begin
			run_q     <= run;
			idle      <= (idle & ~load_next) | rise | take;
			pending   <= avail - CRD_W'(issue);
			in_credit <= issue;
			load      <= load_next;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			core_sample <= in_sample;
		end
	end

	// Upstream only sends on credit, so a free core always exists.
	a_idle_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (idle != '0));

endmodule

//--- hw/taylor_core.sv
`timescale 1ns/100ps

module taylor_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load,
	input  taylor_pkg::sample_s core_sample,
	input  logic                take,
	output logic                done,
	output taylor_pkg::result_s result
);

	localparam int STEP_W = $clog2(taylor_pkg::ORDER + 1);
	localparam int PROD_W = $bits(taylor_pkg::acc_t) + $bits(taylor_pkg::sample_t);

	taylor_pkg::core_state_e  state;
	taylor_pkg::sample_t      x;
	taylor_pkg::tag_t         tag;
	taylor_pkg::acc_t         acc;
	taylor_pkg::acc_t         acc_step;
	logic [STEP_W-1:0]        power;
	logic signed [PROD_W-1:0] prod;

	// One Horner step, floor rounding from the arithmetic shift.
	always_comb begin
		prod = acc * x;
		acc_step = taylor_pkg::acc_t'(prod >>> taylor_pkg::FRAC_BITS)
			+ taylor_pkg::acc_t'(taylor_pkg::COEF[power - STEP_W'(1)]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= taylor_pkg::IDLE;
		end else begin
			case (state)
				taylor_pkg::IDLE: begin
					if (load) begin
						state <= taylor_pkg::EVAL;
					end
				end
				taylor_pkg::EVAL: begin
					if (power == STEP_W'(1)) begin
						state <= taylor_pkg::HOLD; // Last coefficient added.
					end
				end
				taylor_pkg::HOLD: begin
					if (take) begin
						state <= taylor_pkg::IDLE;
					end
				end
				default: state <= taylor_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == taylor_pkg::IDLE && load) begin
			x     <= core_sample.value;
			tag   <= core_sample.tag;
			acc   <= taylor_pkg::acc_t'(taylor_pkg::COEF[taylor_pkg::ORDER]);
			power <= STEP_W'(taylor_pkg::ORDER);
		end else if (state == taylor_pkg::EVAL) begin
			acc   <= acc_step;
			power <= power - STEP_W'(1);
		end
	end

	assign done = (state == taylor_pkg::HOLD);
	assign result = '{value: acc, tag: tag};

	// The arbiter only takes a finished core.
	a_take_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		take |-> (state == taylor_pkg::HOLD));

endmodule

//--- hw/taylor_multicore.sv
`timescale 1ns/100ps

module taylor_multicore #(
	parameter int NUM_CORES = 2,
	parameter int STAGGER_CYCLES = 6,
	parameter int OUT_CREDITS = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  taylor_pkg::sample_s in_sample,
	input  logic                out_credit,
	output logic                in_credit,
	output logic                out_valid,
	output taylor_pkg::result_s out_result
);

	logic [NUM_CORES-1:0] run;
	logic [NUM_CORES-1:0] load;
	logic [NUM_CORES-1:0] take;
	logic [NUM_CORES-1:0] done;
	taylor_pkg::sample_s  core_sample;
	taylor_pkg::result_s  core_result [NUM_CORES];

	reset_stagger #(
		.NUM_CORES      (NUM_CORES),
		.STAGGER_CYCLES (STAGGER_CYCLES)
	) u_reset_stagger (
		.clk   (clk),
		.rst_n (rst_n),
		.run   (run)
	);

	sample_dispatcher #(
		.NUM_CORES (NUM_CORES)
	) u_sample_dispatcher (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.in_valid    (in_valid),
		.in_sample   (in_sample),
		.take        (take),
		.in_credit   (in_credit),
		.load        (load),
		.core_sample (core_sample)
	);

	// All cores share one sample bus, load picks the receiver.
	for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
		taylor_core u_taylor_core (
			.clk         (clk),
			.rst_n       (rst_n),
			.load        (load[g]),
			.core_sample (core_sample),
			.take        (take[g]),
			.done        (done[g]),
			.result      (core_result[g])
		);
	end

	result_arbiter #(
		.NUM_CORES   (NUM_CORES),
		.OUT_CREDITS (OUT_CREDITS)
	) u_result_arbiter (
		.clk         (clk),
		.rst_n       (rst_n),
		.done        (done),
		.core_result (core_result),
		.out_credit  (out_credit),
		.take        (take),
		.out_result  (out_result),
		.out_valid   (out_valid)
	);

endmodule

//--- hw/taylor_pkg.sv
package taylor_pkg;

	// Q2.16 input sample.
	typedef logic signed [18:0] sample_t;

	// Q11.16 accumulator, wide enough for in-range inputs.
	typedef logic signed [27:0] acc_t;

	typedef logic [7:0] tag_t;

	typedef struct packed {
		sample_t value;
		tag_t    tag;
	} sample_s;

	typedef struct packed {
		acc_t value;
		tag_t tag;
	} result_s;

	localparam int FRAC_BITS = 16;
	localparam int ORDER = 5;

	// Sine series x - x^3/6 + x^5/120, indexed by power.
	localparam sample_t COEF [ORDER+1] = '{
		19'sd0,
		19'sd65536,
		19'sd0,
		-19'sd10923,
		19'sd0,
		19'sd546
	};

	typedef enum logic [1:0] {
		IDLE,
		EVAL,
		HOLD
	} core_state_e;

endpackage

//--- project.f
hw/taylor_pkg.sv
hw/reset_stagger.sv
hw/sample_dispatcher.sv
hw/taylor_core.sv
hw/result_arbiter.sv
hw/taylor_multicore.sv
bench/tb_taylor_multicore.sv
